/* Makefile */
VERILATOR  = verilator
TOP        = tb_id_stage
FILELIST   = id_stage.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Finished with errors
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* id_stage.f */
logic/id_pkg.sv
logic/id_decoder.sv
logic/operand_forward.sv
logic/branch_unit.sv
logic/id_issue_reg.sv
logic/id_stage.sv
verification/id_stage_sva.sv
verification/tb_id_stage.sv

/* logic/branch_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module branch_unit
	import id_pkg::*;
(
	input  logic [XLEN-1:0] pc_i,
	input  logic [XLEN-1:0] inst_i,
	input  branch_kind_e    branch_kind_i,
	input  logic [XLEN-1:0] op1_i,
	input  logic [XLEN-1:0] op2_i,
	output logic            taken_o,
	output logic [XLEN-1:0] target_o,
	output logic [XLEN-1:0] link_addr_o
);

	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] branch_off;
	logic [XLEN-1:0] branch_target;
	logic [XLEN-1:0] jump_target;

	assign pc_plus4    = pc_i + 32'd4;
	assign link_addr_o = pc_i + 32'd8;

	// word offset, sign-extended
	assign branch_off    = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign branch_target = pc_plus4 + branch_off;
	// region jump stays inside the current 256 MB segment
	assign jump_target   = {pc_plus4[31:28], inst_i[25:0], 2'b00};

	always_comb begin
		case (branch_kind_i)
			BR_EQ:                 taken_o = (op1_i == op2_i);
			BR_NE:                 taken_o = (op1_i != op2_i);
			BR_JUMP, BR_JUMP_LINK: taken_o = 1'b1;
			default:               taken_o = 1'b0;
		endcase
	end

	assign target_o = (branch_kind_i == BR_JUMP || branch_kind_i == BR_JUMP_LINK) ?
		jump_target : branch_target;

endmodule

`default_nettype wire

/* logic/id_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

module id_decoder
	import id_pkg::*;
(
	input  logic [XLEN-1:0]       inst_i,
	output alu_op_e               alu_op_o,
	output logic                  read1_o,
	output logic                  read2_o,
	output logic [REG_ADDR_W-1:0] src1_o,
	output logic [REG_ADDR_W-1:0] src2_o,
	output logic [REG_ADDR_W-1:0] wd_o,
	output logic                  wreg_o,
	output imm_kind_e             imm_kind_o,
	output logic                  shift_o,
	output branch_kind_e          branch_kind_o
);

	opcode_e               opcode;
	funct_e                funct;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;

	assign opcode = opcode_e'(inst_i[31:26]);
	assign funct  = funct_e'(inst_i[5:0]);
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];

	always_comb begin
		alu_op_o      = ALU_NOP;
		read1_o       = 1'b0;
		read2_o       = 1'b0;
		wd_o          = '0;
		wreg_o        = 1'b0;
		imm_kind_o    = IMM_NONE;
		shift_o       = 1'b0;
		branch_kind_o = BR_NONE;
		case (opcode)
			OP_ORI, OP_ANDI, OP_XORI: begin
				alu_op_o   = (opcode == OP_ORI) ? ALU_ORI :
					(opcode == OP_ANDI) ? ALU_ANDI : ALU_XORI;
				read1_o    = 1'b1;
				imm_kind_o = IMM_ZERO_EXT;
				wd_o       = rt;
				wreg_o     = 1'b1;
			end
			OP_ADDI, OP_ADDIU: begin
				alu_op_o   = (opcode == OP_ADDI) ? ALU_ADDI : ALU_ADDIU;
				read1_o    = 1'b1;
				imm_kind_o = IMM_SIGN_EXT;
				wd_o       = rt;
				wreg_o     = 1'b1;
			end
			OP_LUI: begin
				// rs field is unused, operand 1 stays zero
				alu_op_o   = ALU_LUI;
				imm_kind_o = IMM_UPPER;
				wd_o       = rt;
				wreg_o     = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				alu_op_o      = (opcode == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				read1_o       = 1'b1;
				read2_o       = 1'b1;
				branch_kind_o = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
			end
			OP_J: begin
				alu_op_o      = ALU_J;
				branch_kind_o = BR_JUMP;
			end
			OP_JAL: begin
				alu_op_o      = ALU_JAL;
				branch_kind_o = BR_JUMP_LINK;
				wd_o          = LINK_REG;
				wreg_o        = 1'b1;
			end
			OP_SPECIAL: begin
				case (funct)
					FN_AND:  alu_op_o = ALU_AND;
					FN_OR:   alu_op_o = ALU_OR;
					FN_XOR:  alu_op_o = ALU_XOR;
					FN_NOR:  alu_op_o = ALU_NOR;
					FN_ADD:  alu_op_o = ALU_ADD;
					FN_ADDU: alu_op_o = ALU_ADDU;
					FN_SUB:  alu_op_o = ALU_SUB;
					FN_SUBU: alu_op_o = ALU_SUBU;
					FN_SLT:  alu_op_o = ALU_SLT;
					FN_SLTU: alu_op_o = ALU_SLTU;
					FN_SLL:  alu_op_o = ALU_SLL;
					FN_SRL:  alu_op_o = ALU_SRL;
					FN_SRA:  alu_op_o = ALU_SRA;
					default: alu_op_o = ALU_NOP;
				endcase
				// the all-zero word is the canonical nop, not sll
				if (inst_i == '0) begin
					alu_op_o = ALU_NOP;
				end
				if (alu_op_o != ALU_NOP) begin
					shift_o = funct inside {FN_SLL, FN_SRL, FN_SRA};
					read1_o = !shift_o;
					read2_o = 1'b1;
					wd_o    = rd;
					wreg_o  = 1'b1;
				end
			end
			default: begin
				// unsupported encodings fall through as nop
			end
		endcase
		src1_o = read1_o ? rs : '0;
		src2_o = read2_o ? rt : '0;
	end

endmodule

`default_nettype wire

/* logic/id_issue_reg.sv */
`default_nettype none
`timescale 1ns/1ps

module id_issue_reg
	import id_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  valid_i,
	input  logic [XLEN-1:0]       inst_i,
	input  alu_op_e               alu_op_i,
	input  imm_kind_e             imm_kind_i,
	input  logic                  shift_i,
	input  logic [XLEN-1:0]       fwd1_i,
	input  logic [XLEN-1:0]       fwd2_i,
	input  logic [REG_ADDR_W-1:0] wd_i,
	input  logic                  wreg_i,
	input  logic                  taken_i,
	input  logic [XLEN-1:0]       target_i,
	input  logic [XLEN-1:0]       link_addr_i,
	output logic                  valid_o,
	output alu_op_e               alu_op_o,
	output logic [XLEN-1:0]       op1_o,
	output logic [XLEN-1:0]       op2_o,
	output logic [REG_ADDR_W-1:0] wd_o,
	output logic                  wreg_o,
	output logic                  branch_flag_o,
	output logic [XLEN-1:0]       branch_target_o
);

	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;

	// shift amount wins over link address
	always_comb begin
		if (shift_i) begin
			op1 = {27'b0, inst_i[10:6]};
		end else if (alu_op_i == ALU_JAL) begin
			op1 = link_addr_i;
		end else begin
			op1 = fwd1_i;
		end
	end

	always_comb begin
		case (imm_kind_i)
			IMM_ZERO_EXT: op2 = {16'b0, inst_i[15:0]};
			IMM_SIGN_EXT: op2 = {{16{inst_i[15]}}, inst_i[15:0]};
			IMM_UPPER:    op2 = {inst_i[15:0], 16'b0};
			default:      op2 = fwd2_i;
		endcase
	end

	// control bits
	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_o       <= 1'b0;
			wreg_o        <= 1'b0;
			branch_flag_o <= 1'b0;
		end else begin
			valid_o       <= valid_i;
			wreg_o        <= valid_i & wreg_i;
			branch_flag_o <= valid_i & taken_i;
		end
	end

	// payload only moves with a valid instruction
	always_ff @(posedge clk) begin
		if (valid_i) begin
			alu_op_o        <= alu_op_i;
			op1_o           <= op1;
			op2_o           <= op2;
			wd_o            <= wd_i;
			branch_target_o <= target_i;
		end
	end

endmodule

`default_nettype wire

/* logic/id_pkg.sv */
`default_nettype none

package id_pkg;

	// widths fixed by the MIPS ISA
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_SRC    = 2;

	// jal writes the return address here
	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	typedef enum logic [4:0] {
		ALU_NOP, ALU_ORI, ALU_ANDI, ALU_XORI, ALU_LUI, ALU_ADDI, ALU_ADDIU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_BEQ, ALU_BNE, ALU_J, ALU_JAL
	} alu_op_e;

	// where operand 2 comes from
	typedef enum logic [1:0] {
		IMM_NONE,
		IMM_ZERO_EXT,
		IMM_SIGN_EXT,
		IMM_UPPER
	} imm_kind_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JUMP,
		BR_JUMP_LINK
	} branch_kind_e;

endpackage

`default_nettype wire

/* logic/id_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module id_stage
	import id_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  valid_i,
	input  logic [XLEN-1:0]       pc_i,
	input  logic [XLEN-1:0]       inst_i,
	input  logic                  ex_wreg_i,
	input  logic [REG_ADDR_W-1:0] ex_wd_i,
	input  logic [XLEN-1:0]       ex_wdata_i,
	input  logic                  mem_wreg_i,
	input  logic [REG_ADDR_W-1:0] mem_wd_i,
	input  logic [XLEN-1:0]       mem_wdata_i,
	input  logic [XLEN-1:0]       rf_data1_i,
	input  logic [XLEN-1:0]       rf_data2_i,
	output logic                  rf_read1_o,
	output logic [REG_ADDR_W-1:0] rf_addr1_o,
	output logic                  rf_read2_o,
	output logic [REG_ADDR_W-1:0] rf_addr2_o,
	output logic                  valid_o,
	output alu_op_e               alu_op_o,
	output logic [XLEN-1:0]       op1_o,
	output logic [XLEN-1:0]       op2_o,
	output logic [REG_ADDR_W-1:0] wd_o,
	output logic                  wreg_o,
	output logic                  branch_flag_o,
	output logic [XLEN-1:0]       branch_target_o
);

	alu_op_e               dec_alu_op;
	logic [REG_ADDR_W-1:0] dec_wd;
	logic                  dec_wreg;
	imm_kind_e             dec_imm_kind;
	logic                  dec_shift;
	branch_kind_e          dec_branch_kind;
	logic                  src_read [NUM_SRC];
	logic [REG_ADDR_W-1:0] src_addr [NUM_SRC];
	logic [XLEN-1:0]       src_rf   [NUM_SRC];
	logic [XLEN-1:0]       src_fwd  [NUM_SRC];
	logic                  br_taken;
	logic [XLEN-1:0]       br_target;
	logic [XLEN-1:0]       link_addr;

	id_decoder u_decoder (
		.inst_i        (inst_i),
		.alu_op_o      (dec_alu_op),
		.read1_o       (src_read[0]),
		.read2_o       (src_read[1]),
		.src1_o        (src_addr[0]),
		.src2_o        (src_addr[1]),
		.wd_o          (dec_wd),
		.wreg_o        (dec_wreg),
		.imm_kind_o    (dec_imm_kind),
		.shift_o       (dec_shift),
		.branch_kind_o (dec_branch_kind)
	);

	// register file answers in the same cycle
	assign rf_read1_o = src_read[0];
	assign rf_addr1_o = src_addr[0];
	assign rf_read2_o = src_read[1];
	assign rf_addr2_o = src_addr[1];
	assign src_rf[0]  = rf_data1_i;
	assign src_rf[1]  = rf_data2_i;

	for (genvar i = 0; i < NUM_SRC; i++) begin : g_fwd
		operand_forward u_fwd (
			.read_i      (src_read[i]),
			.src_i       (src_addr[i]),
			.rf_data_i   (src_rf[i]),
			.ex_wreg_i   (ex_wreg_i),
			.ex_wd_i     (ex_wd_i),
			.ex_wdata_i  (ex_wdata_i),
			.mem_wreg_i  (mem_wreg_i),
			.mem_wd_i    (mem_wd_i),
			.mem_wdata_i (mem_wdata_i),
			.value_o     (src_fwd[i])
		);
	end

	// branches compare the bypassed operands
	branch_unit u_branch (
		.pc_i          (pc_i),
		.inst_i        (inst_i),
		.branch_kind_i (dec_branch_kind),
		.op1_i         (src_fwd[0]),
		.op2_i         (src_fwd[1]),
		.taken_o       (br_taken),
		.target_o      (br_target),
		.link_addr_o   (link_addr)
	);

	id_issue_reg u_issue (
		.clk             (clk),
		.reset_i         (reset_i),
		.valid_i         (valid_i),
		.inst_i          (inst_i),
		.alu_op_i        (dec_alu_op),
		.imm_kind_i      (dec_imm_kind),
		.shift_i         (dec_shift),
		.fwd1_i          (src_fwd[0]),
		.fwd2_i          (src_fwd[1]),
		.wd_i            (dec_wd),
		.wreg_i          (dec_wreg),
		.taken_i         (br_taken),
		.target_i        (br_target),
		.link_addr_i     (link_addr),
		.valid_o         (valid_o),
		.alu_op_o        (alu_op_o),
		.op1_o           (op1_o),
		.op2_o           (op2_o),
		.wd_o            (wd_o),
		.wreg_o          (wreg_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o)
	);

endmodule

`default_nettype wire

/* logic/operand_forward.sv */
`default_nettype none
`timescale 1ns/1ps

module operand_forward
	import id_pkg::*;
(
	input  logic                  read_i,
	input  logic [REG_ADDR_W-1:0] src_i,
	input  logic [XLEN-1:0]       rf_data_i,
	input  logic                  ex_wreg_i,
	input  logic [REG_ADDR_W-1:0] ex_wd_i,
	input  logic [XLEN-1:0]       ex_wdata_i,
	input  logic                  mem_wreg_i,
	input  logic [REG_ADDR_W-1:0] mem_wd_i,
	input  logic [XLEN-1:0]       mem_wdata_i,
	output logic [XLEN-1:0]       value_o
);

	always_comb begin
		if (!read_i || src_i == '0) begin
			// $zero never takes a bypass
			value_o = '0;
		end else if (ex_wreg_i && ex_wd_i == src_i) begin
			value_o = ex_wdata_i;
		end else if (mem_wreg_i && mem_wd_i == src_i) begin
			// older result, only if ex has nothing newer
			value_o = mem_wdata_i;
		end else begin
			value_o = rf_data_i;
		end
	end

endmodule

`default_nettype wire

/* verification/id_stage_sva.sv */
`default_nettype none
`timescale 1ns/1ps

module id_stage_sva (
	input logic clk,
	input logic reset_i,
	input logic valid_i,
	input logic valid_o,
	input logic wreg_o,
	input logic branch_flag_o
);

	// control bits never outlive the valid flag
	a_wreg_needs_valid: assert property (@(posedge clk) disable iff (reset_i)
		wreg_o |-> valid_o)
		else $error("wreg_o high while valid_o is low");

	a_branch_needs_valid: assert property (@(posedge clk) disable iff (reset_i)
		branch_flag_o |-> valid_o)
		else $error("branch_flag_o high while valid_o is low");

	// one cycle latency, no stalls
	a_valid_follows_input: assert property (@(posedge clk) disable iff (reset_i)
		!$past(reset_i) |-> valid_o == $past(valid_i))
		else $error("valid_o does not follow valid_i of the previous cycle");

endmodule

bind id_stage id_stage_sva sva0 (
	.clk           (clk),
	.reset_i       (reset_i),
	.valid_i       (valid_i),
	.valid_o       (valid_o),
	.wreg_o        (wreg_o),
	.branch_flag_o (branch_flag_o)
);

`default_nettype wire

/* verification/tb_id_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_id_stage
	import id_pkg::*;
();

	localparam int K_IMM    = 0;
	localparam int K_REG    = 1;
	localparam int K_BRANCH = 2;
	localparam int K_JUMP   = 3;
	localparam int K_FWD    = 4;
	localparam int K_MIX    = 5;

	localparam int N_IMM       = 60;
	localparam int N_REG       = 80;
	localparam int N_FWD       = 80;
	localparam int N_BRANCH    = 60;
	localparam int N_JUMP      = 40;
	localparam int N_MIX       = 80;
	localparam int TOTAL_INST  = N_IMM + N_REG + N_FWD + N_BRANCH + N_JUMP + N_MIX;
	localparam int CYCLE_LIMIT = 2 * TOTAL_INST + 20;

	typedef struct packed {
		logic        valid;
		logic        wreg;
		logic        flag;
		logic        is_branch;
		logic [4:0]  alu;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [4:0]  wd;
		logic [31:0] target;
	} exp_t;

	logic        clk;
	logic        reset_i;
	logic        valid_i;
	logic [31:0] pc_i;
	logic [31:0] inst_i;
	logic        ex_wreg_i;
	logic [4:0]  ex_wd_i;
	logic [31:0] ex_wdata_i;
	logic        mem_wreg_i;
	logic [4:0]  mem_wd_i;
	logic [31:0] mem_wdata_i;
	logic [31:0] rf_data1_i;
	logic [31:0] rf_data2_i;
	logic        rf_read1_o;
	logic [4:0]  rf_addr1_o;
	logic        rf_read2_o;
	logic [4:0]  rf_addr2_o;
	logic        valid_o;
	alu_op_e     alu_op_o;
	logic [31:0] op1_o;
	logic [31:0] op2_o;
	logic [4:0]  wd_o;
	logic        wreg_o;
	logic        branch_flag_o;
	logic [31:0] branch_target_o;

	integer      seed = 78;
	logic [31:0] rf_regs [32];
	exp_t        exp_q [$];
	string       test_name;
	int          test_checks;
	int          test_errors;
	int          total_checks = 0;
	int          total_errors = 0;
	int          tests_run = 0;
	int          cycles = 0;

	logic [5:0] imm_ops [6] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU};
	// non-shift functs first, shifts last
	logic [5:0] reg_fns [13] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_ADD, FN_ADDU, FN_SUB,
		FN_SUBU, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};

	id_stage dut0 (
		.clk             (clk),
		.reset_i         (reset_i),
		.valid_i         (valid_i),
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.ex_wreg_i       (ex_wreg_i),
		.ex_wd_i         (ex_wd_i),
		.ex_wdata_i      (ex_wdata_i),
		.mem_wreg_i      (mem_wreg_i),
		.mem_wd_i        (mem_wd_i),
		.mem_wdata_i     (mem_wdata_i),
		.rf_data1_i      (rf_data1_i),
		.rf_data2_i      (rf_data2_i),
		.rf_read1_o      (rf_read1_o),
		.rf_addr1_o      (rf_addr1_o),
		.rf_read2_o      (rf_read2_o),
		.rf_addr2_o      (rf_addr2_o),
		.valid_o         (valid_o),
		.alu_op_o        (alu_op_o),
		.op1_o           (op1_o),
		.op2_o           (op2_o),
		.wd_o            (wd_o),
		.wreg_o          (wreg_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o)
	);

	// register file model, same-cycle read
	assign rf_data1_i = rf_regs[rf_addr1_o];
	assign rf_data2_i = rf_regs[rf_addr2_o];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic logic [4:0] pick_dest(input logic [1:0] sel, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] other);
		case (sel)
			2'd0:    return rs;
			2'd1:    return rt;
			default: return other;
		endcase
	endfunction

	// bypass priority: ex, then mem, then register file
	function automatic logic [31:0] src_value(input logic [4:0] r);
		if (r == 5'd0) return '0;
		if (ex_wreg_i && ex_wd_i == r) return ex_wdata_i;
		if (mem_wreg_i && mem_wd_i == r) return mem_wdata_i;
		return rf_regs[r];
	endfunction

	function automatic logic [4:0] expected_alu(input logic [5:0] op, input logic [5:0] fn);
		case (op)
			OP_ORI:   return ALU_ORI;
			OP_ANDI:  return ALU_ANDI;
			OP_XORI:  return ALU_XORI;
			OP_LUI:   return ALU_LUI;
			OP_ADDI:  return ALU_ADDI;
			OP_ADDIU: return ALU_ADDIU;
			OP_BEQ:   return ALU_BEQ;
			OP_BNE:   return ALU_BNE;
			OP_J:     return ALU_J;
			OP_JAL:   return ALU_JAL;
			OP_SPECIAL: begin
				case (fn)
					FN_AND:  return ALU_AND;
					FN_OR:   return ALU_OR;
					FN_XOR:  return ALU_XOR;
					FN_NOR:  return ALU_NOR;
					FN_ADD:  return ALU_ADD;
					FN_ADDU: return ALU_ADDU;
					FN_SUB:  return ALU_SUB;
					FN_SUBU: return ALU_SUBU;
					FN_SLT:  return ALU_SLT;
					FN_SLTU: return ALU_SLTU;
					FN_SLL:  return ALU_SLL;
					FN_SRL:  return ALU_SRL;
					FN_SRA:  return ALU_SRA;
					default: return ALU_NOP;
				endcase
			end
			default:  return ALU_NOP;
		endcase
	endfunction

	// bit 0 is the rs read, bit 1 the rt read; lui has no register source
	function automatic logic [1:0] expected_reads(input logic [31:0] inst);
		logic [5:0] op;
		logic       kept;
		op   = inst[31:26];
		kept = (inst != '0) && (expected_alu(op, inst[5:0]) != ALU_NOP);
		case (op)
			OP_ORI, OP_ANDI, OP_XORI, OP_ADDI, OP_ADDIU: return 2'b01;
			OP_BEQ, OP_BNE: return 2'b11;
			OP_SPECIAL: begin
				if (!kept) return 2'b00;
				if (inst[5:0] inside {FN_SLL, FN_SRL, FN_SRA}) return 2'b10;
				return 2'b11;
			end
			default: return 2'b00;
		endcase
	endfunction

	// expected stage outputs for what is on the inputs right now
	function automatic exp_t predict();
		exp_t        e;
		logic [5:0]  op;
		logic [15:0] imm;
		logic [31:0] pc4;
		op  = inst_i[31:26];
		imm = inst_i[15:0];
		pc4 = pc_i + 32'd4;
		e = '0;
		e.valid = valid_i;
		if (!valid_i) return e;
		e.alu = (inst_i == '0) ? 5'(ALU_NOP) : expected_alu(op, inst_i[5:0]);
		e.target = pc4 + {{14{imm[15]}}, imm, 2'b00};
		case (op)
			OP_ORI, OP_ANDI, OP_XORI: begin
				e.op1 = src_value(inst_i[25:21]);
				e.op2 = {16'h0, imm};
			end
			OP_ADDI, OP_ADDIU: begin
				e.op1 = src_value(inst_i[25:21]);
				e.op2 = {{16{imm[15]}}, imm};
			end
			OP_LUI: e.op2 = {imm, 16'h0};
			OP_BEQ, OP_BNE: begin
				e.op1 = src_value(inst_i[25:21]);
				e.op2 = src_value(inst_i[20:16]);
				e.is_branch = 1'b1;
				e.flag = (op == OP_BEQ) ? (e.op1 == e.op2) : (e.op1 != e.op2);
			end
			OP_J, OP_JAL: begin
				e.is_branch = 1'b1;
				e.flag = 1'b1;
				e.target = {pc4[31:28], inst_i[25:0], 2'b00};
				if (op == OP_JAL) begin
					e.op1 = pc_i + 32'd8;
					e.wd = LINK_REG;
					e.wreg = 1'b1;
				end
			end
			OP_SPECIAL: begin
				if (e.alu inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
					e.op1 = {27'h0, inst_i[10:6]};
				end else begin
					e.op1 = src_value(inst_i[25:21]);
				end
				e.op2 = src_value(inst_i[20:16]);
				e.wd = inst_i[15:11];
				e.wreg = (e.alu != ALU_NOP);
			end
			default: ;
		endcase
		if (op inside {OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU}) begin
			e.wd = inst_i[20:16];
			e.wreg = 1'b1;
		end
		return e;
	endfunction

	function automatic logic [31:0] build_inst(input int kind);
		logic [31:0] w;
		logic [31:0] r;
		logic [4:0]  rt;
		int          idx;
		w = next_random();
		r = next_random();
		case (kind)
			K_IMM: begin
				idx = int'(r[7:0]) % 6;
				return {imm_ops[idx], w[25:0]};
			end
			K_REG: begin
				idx = int'(r[3:0]);
				if (idx < 13) return {6'h00, w[25:6], reg_fns[idx]};
				// jr funct and lw opcode are outside the kept set
				if (idx == 13) return {6'h00, w[25:6], 6'b001000};
				if (idx == 14) return '0;
				return {6'b100011, w[25:0]};
			end
			K_BRANCH: begin
				// same register on both sides forces equal operands
				rt = r[1] ? w[25:21] : w[20:16];
				return {r[0] ? OP_BNE : OP_BEQ, w[25:21], rt, w[15:0]};
			end
			K_JUMP: return {r[0] ? OP_JAL : OP_J, w[25:0]};
			K_FWD: begin
				// registers 0..3 only, so bypass hits and $zero are frequent
				idx = int'(r[4:1]) % 10;
				if (r[0]) return {OP_ORI, 3'b0, w[22:21], 3'b0, w[17:16], w[15:0]};
				return {6'h00, 3'b0, w[22:21], 3'b0, w[17:16], w[15:6], reg_fns[idx]};
			end
			default: return '0;
		endcase
	endfunction

	task automatic drive_bypass(input logic dense);
		logic [31:0] w;
		w = next_random();
		ex_wreg_i   = w[0] | dense;
		mem_wreg_i  = w[1] | dense;
		ex_wd_i     = pick_dest(w[3:2], inst_i[25:21], inst_i[20:16], w[8:4]);
		mem_wd_i    = pick_dest(w[10:9], inst_i[25:21], inst_i[20:16], w[15:11]);
		ex_wdata_i  = next_random();
		mem_wdata_i = next_random();
	endtask

	task automatic check_value(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		test_checks++;
		if (expected !== actual) begin
			test_errors++;
			$display("[FAIL] %s %s: expected %h actual %h", test_name, field, expected, actual);
		end
	endtask

	// combinational read requests for the instruction on the inputs
	task automatic check_reads();
		logic [1:0] rd;
		rd = expected_reads(inst_i);
		check_value("rf_read1_o", 32'(rd[0]), 32'(rf_read1_o));
		check_value("rf_read2_o", 32'(rd[1]), 32'(rf_read2_o));
		if (rd[0]) begin
			check_value("rf_addr1_o", 32'(inst_i[25:21]), 32'(rf_addr1_o));
		end
		if (rd[1]) begin
			check_value("rf_addr2_o", 32'(inst_i[20:16]), 32'(rf_addr2_o));
		end
	endtask

	task automatic compare_pending();
		exp_t e;
		if (exp_q.size() == 0) return;
		e = exp_q.pop_front();
		check_value("valid_o", 32'(e.valid), 32'(valid_o));
		check_value("wreg_o", 32'(e.wreg), 32'(wreg_o));
		check_value("branch_flag_o", 32'(e.flag), 32'(branch_flag_o));
		if (e.valid) begin
			check_value("alu_op_o", 32'(e.alu), 32'(alu_op_o));
			// nop payload is don't-care
			if (e.alu != ALU_NOP) begin
				check_value("op1_o", e.op1, op1_o);
				check_value("op2_o", e.op2, op2_o);
				check_value("wd_o", 32'(e.wd), 32'(wd_o));
			end
			if (e.is_branch) begin
				check_value("branch_target_o", e.target, branch_target_o);
			end
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic finish_test();
		$display("test %-12s %0d checks, %0d errors", test_name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		tests_run++;
	endtask

	task automatic run_test(input string name, input int kind, input int count);
		logic [31:0] w;
		int          k;
		start_test(name);
		for (int n = 0; n <= count; n++) begin
			@(posedge clk);
			#1;
			compare_pending();
			w = next_random();
			k = (kind == K_MIX) ? int'(w[9:8]) : kind;
			pc_i = next_random() & 32'hffff_fffc;
			inst_i = build_inst(k);
			drive_bypass(kind == K_FWD);
			// last pass is an idle cycle that flushes the final result
			valid_i = (n < count) && (kind != K_MIX || w[0]);
			exp_q.push_back(predict());
			#1;
			check_reads();
		end
		@(posedge clk);
		#1;
		compare_pending();
		finish_test();
	endtask

	initial begin
		reset_i     = 1'b1;
		// a valid jal during reset must not reach the outputs
		valid_i     = 1'b1;
		pc_i        = '0;
		inst_i      = {OP_JAL, 26'h0};
		ex_wreg_i   = 1'b0;
		ex_wd_i     = '0;
		ex_wdata_i  = '0;
		mem_wreg_i  = 1'b0;
		mem_wd_i    = '0;
		mem_wdata_i = '0;
		for (int i = 0; i < 32; i++) begin
			rf_regs[i] = next_random();
		end

		start_test("reset");
		repeat (3) @(posedge clk);
		#1;
		reset_i = 1'b0;
		valid_i = 1'b0;
		check_value("valid_o", 32'h0, 32'(valid_o));
		check_value("wreg_o", 32'h0, 32'(wreg_o));
		check_value("branch_flag_o", 32'h0, 32'(branch_flag_o));
		finish_test();

		run_test("imm_ops", K_IMM, N_IMM);
		run_test("reg_ops", K_REG, N_REG);
		run_test("forwarding", K_FWD, N_FWD);
		run_test("branches", K_BRANCH, N_BRANCH);
		run_test("jumps", K_JUMP, N_JUMP);
		run_test("idle_mix", K_MIX, N_MIX);

		$display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
